// ==== Bender.yml ====
package:
  name: cpu_tail

sources:
  - files:
      - source/cpu_tail_pkg.sv
      - source/execute_ctrl_stage.sv
      - source/pipeline_ctrl.sv
      - source/load_store_unit.sv
      - source/spr_file.sv
      - source/writeback_stage.sv
      - source/cpu_tail.sv
  - target: simulation
    files:
      - sim/cpu_tail_checker.sv
      - sim/cpu_tail_tb.sv

// ==== cpu_tail.f ====
source/cpu_tail_pkg.sv
source/execute_ctrl_stage.sv
source/pipeline_ctrl.sv
source/load_store_unit.sv
source/spr_file.sv
source/writeback_stage.sv
source/cpu_tail.sv
sim/cpu_tail_checker.sv
sim/cpu_tail_tb.sv

// ==== sim/cpu_tail_checker.sv ====
// scoreboard for the cpu_tail testbench
// compares every writeback and exception report with the queue of predicted
// events, in program order, and checks the status bits when asked to
`timescale 1ns/1ps

module cpu_tail_checker (
   input logic                  clk,
   input logic                  rst,
   input cpu_tail_pkg::wb_t     wb_i,
   input cpu_tail_pkg::except_t except_i,
   input logic                  flag_i,
   input logic                  carry_i
);

   typedef struct packed {
      logic                  is_except;
      cpu_tail_pkg::wb_t     wb;
      cpu_tail_pkg::except_t exc;
   } event_t;

   event_t exp_q[$];
   int     check_count = 0;
   int     error_count = 0;

   function void expect_wb(input cpu_tail_pkg::wb_t wb);
      event_t ev;
      ev = '0;
      ev.wb = wb;
      exp_q.push_back(ev);
   endfunction

   function void expect_except(input cpu_tail_pkg::except_t exc);
      event_t ev;
      ev = '0;
      ev.is_except = 1'b1;
      ev.exc = exc;
      exp_q.push_back(ev);
   endfunction

   function int pending();
      return exp_q.size();
   endfunction

   function void compare_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
      check_count++;
      if (expected !== actual) begin
         error_count++;
         $display("CHECK FAILED %s: expected %h, got %h at %0t", name, expected, actual, $time);
      end
   endfunction

   function void check_status(input logic exp_flag, input logic exp_carry);
      compare_field("flag_o", {31'd0, exp_flag}, {31'd0, flag_i});
      compare_field("carry_o", {31'd0, exp_carry}, {31'd0, carry_i});
   endfunction

   // outputs are registered or decoded from registers, so the falling edge sees them settled
   // a writeback of an older instruction can share a cycle with a newer exception
   always @(negedge clk) begin : sample
      event_t ev;
      if (!rst) begin
         if (wb_i.we) begin
            if (exp_q.size() == 0 || exp_q[0].is_except) begin
               error_count++;
               $display("writeback to register %0d with data %h was not expected at %0t",
                        wb_i.adr, wb_i.data, $time);
            end else begin
               ev = exp_q.pop_front();
               compare_field("wb_o.adr", {27'd0, ev.wb.adr}, {27'd0, wb_i.adr});
               compare_field("wb_o.data", ev.wb.data, wb_i.data);
            end
         end
         if (except_i.valid) begin
            if (exp_q.size() == 0 || !exp_q[0].is_except) begin
               error_count++;
               $display("exception with cause %0d at pc %h was not expected at %0t",
                        except_i.cause, except_i.epc, $time);
            end else begin
               ev = exp_q.pop_front();
               compare_field("except_o.cause", {29'd0, ev.exc.cause}, {29'd0, except_i.cause});
               compare_field("except_o.epc", ev.exc.epc, except_i.epc);
            end
         end
      end
   end

endmodule

// ==== sim/cpu_tail_tb.sv ====
// testbench for cpu_tail
// feeds random decoded instructions through the execute handshake, predicts
// writebacks, exceptions and status bits, and hands the predictions to the checker
`timescale 1ns/1ps

module cpu_tail_tb;

   localparam int DMEM_WORDS     = 64;
   localparam int SPR_ACK_DELAY  = 2;
   localparam int NUM_INSNS      = 300;
   localparam int RESET_CYCLES   = 16;
   localparam int TIMEOUT_CYCLES = 40 * NUM_INSNS + RESET_CYCLES;

   logic                    clk = 1'b0;
   logic                    rst;
   cpu_tail_pkg::exe_insn_t exe_i;
   logic                    padv_execute_o;
   cpu_tail_pkg::except_t   except_o;
   cpu_tail_pkg::wb_t       wb_o;
   logic                    flag_o;
   logic                    carry_o;

   logic [31:0]             rng_state = 32'd89;
   logic [7:0]              ref_bytes [4*DMEM_WORDS] = '{default: '0};
   cpu_tail_pkg::word_t     ref_spr [8] = '{default: '0};
   logic                    ref_flag = 1'b0;
   logic                    ref_carry = 1'b0;

   always #5 clk = ~clk;

   cpu_tail #(
      .DMEM_WORDS    (DMEM_WORDS),
      .SPR_ACK_DELAY (SPR_ACK_DELAY)
   ) cpu_tail_inst (
      .clk            (clk),
      .rst            (rst),
      .exe_i          (exe_i),
      .padv_execute_o (padv_execute_o),
      .except_o       (except_o),
      .wb_o           (wb_o),
      .flag_o         (flag_o),
      .carry_o        (carry_o)
   );

   cpu_tail_checker check_inst (
      .clk      (clk),
      .rst      (rst),
      .wb_i     (wb_o),
      .except_i (except_o),
      .flag_i   (flag_o),
      .carry_i  (carry_o)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   // the low bits of the generator are weak, so two upper halves make a word
   function automatic logic [31:0] next_random();
      logic [15:0] hi;
      rng_state = lcg_next(rng_state);
      hi = rng_state[31:16];
      rng_state = lcg_next(rng_state);
      return {hi, rng_state[31:16]};
   endfunction

   function automatic cpu_tail_pkg::exe_insn_t random_insn(input cpu_tail_pkg::addr_t pc);
      cpu_tail_pkg::exe_insn_t x;
      logic [31:0]             r;
      logic [31:0]             s;
      cpu_tail_pkg::addr_t     adr;
      logic [3:0]              ifault;
      r = next_random();
      s = next_random();
      x = '0;
      x.valid = 1'b1;
      x.op = cpu_tail_pkg::op_kind_e'(3'(1 + (r[7:0] % 6)));
      x.rfd_adr = r[12:8];
      x.rf_wb = (x.op != cpu_tail_pkg::OP_STORE) && (x.op != cpu_tail_pkg::OP_MTSPR) &&
                (r[15:13] != 3'd0);
      x.alu_result = next_random();
      x.jal_result = next_random();
      x.rfb = next_random();
      x.pc = pc;
      x.lsu_length = 2'(r[17:16] % 3);
      x.lsu_zext = r[18];
      x.flag_set = s[1:0] == 2'd0;
      x.flag_clear = s[3:2] == 2'd0;
      x.carry_set = s[21:20] == 2'd0;
      x.carry_clear = s[23:22] == 2'd0;
      // sixteen words cover both latencies, offsets stay legal unless a fault is rolled
      adr = {26'd0, s[7:4], 2'b00};
      if (x.lsu_length == 2'd0) begin
         adr[1:0] = s[9:8];
      end else if (x.lsu_length == 2'd1) begin
         adr[1] = s[8];
      end
      if (r[22:20] == 3'd0) begin
         adr[0] = 1'b1;
      end
      if (r[25:23] == 3'd0) begin
         adr = adr + 32'(4 * DMEM_WORDS * (1 + s[11:10]));
      end
      if (x.op == cpu_tail_pkg::OP_MFSPR || x.op == cpu_tail_pkg::OP_MTSPR) begin
         adr = {29'd0, s[14:12]};
      end
      x.adder_result = adr;
      if (r[28:26] == 3'd0) begin
         ifault = s[19:16];
         if (ifault == 4'd0) begin
            ifault = 4'b1000;
         end
         {x.except_trap, x.except_syscall, x.except_illegal, x.except_ibus_err} = ifault;
      end
      return x;
   endfunction

   // predicts the architectural effect of one accepted instruction
   function void reference_model(input cpu_tail_pkg::exe_insn_t x);
      cpu_tail_pkg::except_cause_e cause;
      cpu_tail_pkg::except_t       exc;
      cpu_tail_pkg::wb_t           wb;
      cpu_tail_pkg::addr_t         a;
      cpu_tail_pkg::word_t         data;
      logic                        is_mem;
      int                          nbytes;
      a = x.adder_result;
      nbytes = 1 << x.lsu_length;
      is_mem = (x.op == cpu_tail_pkg::OP_LOAD) || (x.op == cpu_tail_pkg::OP_STORE);
      data = x.alu_result;
      if (x.except_ibus_err) cause = cpu_tail_pkg::EXC_IBUS;
      else if (x.except_illegal) cause = cpu_tail_pkg::EXC_ILLEGAL;
      else if (x.except_syscall) cause = cpu_tail_pkg::EXC_SYSCALL;
      else if (x.except_trap) cause = cpu_tail_pkg::EXC_TRAP;
      else if (is_mem && a >= 4 * DMEM_WORDS) cause = cpu_tail_pkg::EXC_DBUS;
      else if (is_mem && (a % nbytes) != 0) cause = cpu_tail_pkg::EXC_ALIGN;
      else cause = cpu_tail_pkg::EXC_NONE;
      if (cause != cpu_tail_pkg::EXC_NONE) begin
         exc.valid = 1'b1;
         exc.cause = cause;
         exc.epc = x.pc;
         check_inst.expect_except(exc);
         return;
      end
      case (x.op)
         cpu_tail_pkg::OP_JAL: data = x.jal_result;
         cpu_tail_pkg::OP_STORE: begin
            for (int k = 0; k < nbytes; k++) begin
               ref_bytes[a + k] = x.rfb[8*k +: 8];
            end
         end
         cpu_tail_pkg::OP_LOAD: begin
            data = '0;
            for (int k = 0; k < nbytes; k++) begin
               data[8*k +: 8] = ref_bytes[a + k];
            end
            if (!x.lsu_zext && nbytes < 4 && data[8*nbytes-1]) begin
               data = data | (32'hffff_ffff << (8 * nbytes));
            end
         end
         cpu_tail_pkg::OP_MTSPR: ref_spr[a[2:0]] = x.rfb;
         cpu_tail_pkg::OP_MFSPR: data = ref_spr[a[2:0]];
         default: ;
      endcase
      if (x.rf_wb) begin
         wb.we = 1'b1;
         wb.adr = x.rfd_adr;
         wb.data = data;
         check_inst.expect_wb(wb);
      end
      if (x.flag_set) ref_flag = 1'b1;
      else if (x.flag_clear) ref_flag = 1'b0;
      if (x.carry_set) ref_carry = 1'b1;
      else if (x.carry_clear) ref_carry = 1'b0;
   endfunction

   // holds the instruction until the DUT pulses padv_execute_o for it
   task automatic issue(input cpu_tail_pkg::exe_insn_t insn);
      logic taken;
      exe_i = insn;
      taken = 1'b0;
      while (!taken) begin
         @(negedge clk);
         taken = padv_execute_o;
         @(posedge clk);
         #1;
      end
      reference_model(insn);
   endtask

   initial begin : stimulus
      cpu_tail_pkg::addr_t pc;
      logic [31:0]         r;
      rst = 1'b1;
      exe_i = '0;
      pc = 32'h0000_2000;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;
      for (int i = 0; i < NUM_INSNS; i++) begin
         r = next_random();
         if (r[2:0] == 3'd0) begin
            exe_i = '0;
            @(posedge clk);
            #1;
         end
         issue(random_insn(pc));
         pc = pc + 32'd4;
      end
      exe_i = '0;
      while (check_inst.pending() != 0) begin
         @(posedge clk);
      end
      repeat (20) @(posedge clk);
      check_inst.check_status(ref_flag, ref_carry);
      $display("checks: %0d, errors: %0d", check_inst.check_count, check_inst.error_count);
      if (check_inst.error_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   initial begin : watchdog
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("timeout: %0d predicted results never arrived within %0d cycles",
               check_inst.pending(), TIMEOUT_CYCLES);
      $display("checks: %0d, errors: %0d", check_inst.check_count, check_inst.error_count + 1);
      $display("Errors found");
      $finish;
   end

endmodule

// ==== source/cpu_tail.sv ====
// top level of the pipeline tail
// takes one decoded execute-stage instruction per padv_execute_o pulse and
// returns writebacks, precise exceptions and the flag and carry bits
`timescale 1ns/1ps

module cpu_tail #(
   parameter int DMEM_WORDS    = 64,
   parameter int SPR_ACK_DELAY = 2
) (
   input  logic                    clk,
   input  logic                    rst,
   input  cpu_tail_pkg::exe_insn_t exe_i,
   output logic                    padv_execute_o,
   output cpu_tail_pkg::except_t   except_o,
   output cpu_tail_pkg::wb_t       wb_o,
   output logic                    flag_o,
   output logic                    carry_o
);

   cpu_tail_pkg::ctrl_insn_t ctrl;
   logic [5:0]               ctrl_except;
   cpu_tail_pkg::addr_t      pc_ctrl;
   logic                     wb_rf_wb;
   cpu_tail_pkg::reg_adr_t   wb_rfd_adr;
   logic                     padv_execute;
   logic                     padv_ctrl;
   logic                     pipeline_flush;
   logic                     lsu_valid;
   logic                     lsu_except_dbus;
   logic                     lsu_except_align;
   cpu_tail_pkg::word_t      lsu_rdata;
   logic                     mfspr_ack;
   logic                     mtspr_ack;
   cpu_tail_pkg::word_t      spr_rdata;

   assign padv_execute_o = padv_execute;

   execute_ctrl_stage execute_ctrl_stage_inst (
      .clk                (clk),
      .rst                (rst),
      .exe_i              (exe_i),
      .padv_execute_i     (padv_execute),
      .padv_ctrl_i        (padv_ctrl),
      .pipeline_flush_i   (pipeline_flush),
      .lsu_valid_i        (lsu_valid),
      .lsu_except_dbus_i  (lsu_except_dbus),
      .lsu_except_align_i (lsu_except_align),
      .mfspr_ack_i        (mfspr_ack),
      .ctrl_o             (ctrl),
      .ctrl_except_o      (ctrl_except),
      .pc_ctrl_o          (pc_ctrl),
      .wb_rf_wb_o         (wb_rf_wb),
      .wb_rfd_adr_o       (wb_rfd_adr)
   );

   pipeline_ctrl pipeline_ctrl_inst (
      .clk              (clk),
      .rst              (rst),
      .exe_valid_i      (exe_i.valid),
      .ctrl_op_i        (ctrl.op),
      .ctrl_except_i    (ctrl_except),
      .pc_ctrl_i        (pc_ctrl),
      .lsu_valid_i      (lsu_valid),
      .mfspr_ack_i      (mfspr_ack),
      .mtspr_ack_i      (mtspr_ack),
      .padv_execute_o   (padv_execute),
      .padv_ctrl_o      (padv_ctrl),
      .pipeline_flush_o (pipeline_flush),
      .except_o         (except_o)
   );

   // any latched cause keeps a faulting load or store off the memory
   load_store_unit #(
      .DMEM_WORDS (DMEM_WORDS)
   ) load_store_unit_inst (
      .clk                (clk),
      .rst                (rst),
      .ctrl_i             (ctrl),
      .kill_i             (|ctrl_except),
      .lsu_valid_o        (lsu_valid),
      .lsu_except_dbus_o  (lsu_except_dbus),
      .lsu_except_align_o (lsu_except_align),
      .rdata_o            (lsu_rdata)
   );

   spr_file #(
      .SPR_ACK_DELAY (SPR_ACK_DELAY)
   ) spr_file_inst (
      .clk         (clk),
      .rst         (rst),
      .ctrl_op_i   (ctrl.op),
      .spr_adr_i   (ctrl.lsu_adr[2:0]),
      .wdata_i     (ctrl.rfb),
      .mfspr_ack_o (mfspr_ack),
      .mtspr_ack_o (mtspr_ack),
      .rdata_o     (spr_rdata)
   );

   writeback_stage writeback_stage_inst (
      .clk          (clk),
      .rst          (rst),
      .ctrl_i       (ctrl),
      .wb_rf_wb_i   (wb_rf_wb),
      .wb_rfd_adr_i (wb_rfd_adr),
      .lsu_rdata_i  (lsu_rdata),
      .spr_rdata_i  (spr_rdata),
      .padv_ctrl_i  (padv_ctrl),
      .wb_o         (wb_o),
      .flag_o       (flag_o),
      .carry_o      (carry_o)
   );

endmodule

// ==== source/cpu_tail_pkg.sv ====
// shared widths, operation and cause encodings, and stage records for cpu_tail
// modules refer to these by scoped names such as cpu_tail_pkg::word_t
package cpu_tail_pkg;

   typedef logic [31:0] word_t;
   typedef logic [31:0] addr_t;
   typedef logic [4:0]  reg_adr_t;
   typedef logic [2:0]  spr_adr_t;
   // 0 byte, 1 halfword, 2 word
   typedef logic [1:0]  lsu_len_t;

   localparam word_t RESET_PC = 32'h0000_0100;

   typedef enum logic [2:0] {
      OP_NOP, OP_ALU, OP_JAL, OP_LOAD, OP_STORE, OP_MFSPR, OP_MTSPR
   } op_kind_e;

   // cause values follow the bit order of the latched exception vector, plus one
   typedef enum logic [2:0] {
      EXC_NONE, EXC_IBUS, EXC_ILLEGAL, EXC_SYSCALL, EXC_TRAP, EXC_DBUS, EXC_ALIGN
   } except_cause_e;

   typedef struct packed {
      logic     valid;
      op_kind_e op;
      logic     rf_wb;
      reg_adr_t rfd_adr;
      word_t    alu_result;
      word_t    adder_result;
      word_t    jal_result;
      word_t    rfb;
      addr_t    pc;
      lsu_len_t lsu_length;
      logic     lsu_zext;
      logic     flag_set;
      logic     flag_clear;
      logic     carry_set;
      logic     carry_clear;
      logic     except_ibus_err;
      logic     except_illegal;
      logic     except_syscall;
      logic     except_trap;
   } exe_insn_t;

   typedef struct packed {
      op_kind_e op;
      logic     rf_wb;
      reg_adr_t rfd_adr;
      word_t    result;
      addr_t    lsu_adr;
      word_t    rfb;
      addr_t    pc;
      lsu_len_t lsu_length;
      logic     lsu_zext;
      logic     flag_set;
      logic     flag_clear;
      logic     carry_set;
      logic     carry_clear;
   } ctrl_insn_t;

   typedef struct packed {
      logic          valid;
      except_cause_e cause;
      addr_t         epc;
   } except_t;

   typedef struct packed {
      logic     we;
      reg_adr_t adr;
      word_t    data;
   } wb_t;

endpackage

// ==== source/execute_ctrl_stage.sv ====
// execute to control stage register
// captures the decoded instruction on padv_execute, latches exception causes
// and holds off the writeback enable of loads and mfspr until they complete
`timescale 1ns/1ps

module execute_ctrl_stage (
   input  logic                     clk,
   input  logic                     rst,
   input  cpu_tail_pkg::exe_insn_t  exe_i,
   input  logic                     padv_execute_i,
   input  logic                     padv_ctrl_i,
   input  logic                     pipeline_flush_i,
   input  logic                     lsu_valid_i,
   input  logic                     lsu_except_dbus_i,
   input  logic                     lsu_except_align_i,
   input  logic                     mfspr_ack_i,
   output cpu_tail_pkg::ctrl_insn_t ctrl_o,
   output logic [5:0]               ctrl_except_o,
   output cpu_tail_pkg::addr_t      pc_ctrl_o,
   output logic                     wb_rf_wb_o,
   output cpu_tail_pkg::reg_adr_t   wb_rfd_adr_o
);

   cpu_tail_pkg::op_kind_e op_q;
   logic                   rf_wb_q;
   cpu_tail_pkg::addr_t    pc_q;
   logic [3:0]             status_q;
   logic [5:0]             except_q;
   cpu_tail_pkg::reg_adr_t rfd_adr_q;
   cpu_tail_pkg::word_t    result_q;
   cpu_tail_pkg::addr_t    lsu_adr_q;
   cpu_tail_pkg::word_t    rfb_q;
   cpu_tail_pkg::lsu_len_t lsu_len_q;
   logic                   lsu_zext_q;
   logic                   exe_take;
   logic                   exe_bus_op;
   logic                   lsu_kill;
   logic                   load_done;
   logic                   mfspr_done;

   assign exe_take   = padv_execute_i & exe_i.valid;
   assign exe_bus_op = exe_i.op inside {cpu_tail_pkg::OP_LOAD, cpu_tail_pkg::OP_STORE,
                                        cpu_tail_pkg::OP_MFSPR, cpu_tail_pkg::OP_MTSPR};
   assign lsu_kill   = lsu_except_dbus_i | lsu_except_align_i;
   assign load_done  = (op_q == cpu_tail_pkg::OP_LOAD) & lsu_valid_i;
   assign mfspr_done = (op_q == cpu_tail_pkg::OP_MFSPR) & mfspr_ack_i;

   // the op leaves the stage when it advances, and a faulting access dies on
   // the edge that latches its cause
   always_ff @(posedge clk) begin
      if (rst | pipeline_flush_i) begin
         op_q <= cpu_tail_pkg::OP_NOP;
      end else if (padv_execute_i) begin
         op_q <= exe_i.valid ? exe_i.op : cpu_tail_pkg::OP_NOP;
      end else if (lsu_kill | padv_ctrl_i) begin
         op_q <= cpu_tail_pkg::OP_NOP;
      end
   end

   // once a load or mfspr has delivered its data the register write is spent
   always_ff @(posedge clk) begin
      if (rst | pipeline_flush_i) begin
         rf_wb_q <= 1'b0;
      end else if (padv_execute_i) begin
         rf_wb_q <= exe_i.valid & exe_i.rf_wb;
      end else if (load_done | mfspr_done | lsu_kill) begin
         rf_wb_q <= 1'b0;
      end
   end

   // a bubble leaves pc_ctrl at the last real instruction
   always_ff @(posedge clk) begin
      if (rst) begin
         pc_q     <= cpu_tail_pkg::RESET_PC;
         status_q <= '0;
      end else if (exe_take) begin
         pc_q     <= exe_i.pc;
         status_q <= {exe_i.carry_clear, exe_i.carry_set, exe_i.flag_clear, exe_i.flag_set};
      end
   end

   // bit order: ibus, illegal, syscall, trap, dbus, align
   always_ff @(posedge clk) begin
      if (rst | pipeline_flush_i) begin
         except_q <= '0;
      end else begin
         if (exe_take) begin
            except_q[3:0] <= {exe_i.except_trap, exe_i.except_syscall,
                              exe_i.except_illegal, exe_i.except_ibus_err};
         end
         except_q[4] <= lsu_except_dbus_i;
         except_q[5] <= lsu_except_align_i;
      end
   end

   always_ff @(posedge clk) begin
      if (padv_execute_i) begin
         rfd_adr_q  <= exe_i.rfd_adr;
         rfb_q      <= exe_i.rfb;
         lsu_len_q  <= exe_i.lsu_length;
         lsu_zext_q <= exe_i.lsu_zext;
         // bus and SPR ops need the address, everything else the result
         if (exe_bus_op) begin
            lsu_adr_q <= exe_i.adder_result;
         end else if (exe_i.op == cpu_tail_pkg::OP_JAL) begin
            result_q <= exe_i.jal_result;
         end else begin
            result_q <= exe_i.alu_result;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst | pipeline_flush_i) begin
         wb_rf_wb_o <= 1'b0;
      end else if (op_q == cpu_tail_pkg::OP_MFSPR) begin
         wb_rf_wb_o <= rf_wb_q & mfspr_ack_i;
      end else if (op_q == cpu_tail_pkg::OP_LOAD) begin
         wb_rf_wb_o <= rf_wb_q & lsu_valid_i;
      end else begin
         wb_rf_wb_o <= rf_wb_q & padv_ctrl_i;
      end
   end

   always_ff @(posedge clk) begin
      wb_rfd_adr_o <= rfd_adr_q;
   end

   assign ctrl_o = '{
      op:          op_q,
      rf_wb:       rf_wb_q,
      rfd_adr:     rfd_adr_q,
      result:      result_q,
      lsu_adr:     lsu_adr_q,
      rfb:         rfb_q,
      pc:          pc_q,
      lsu_length:  lsu_len_q,
      lsu_zext:    lsu_zext_q,
      flag_set:    status_q[0],
      flag_clear:  status_q[1],
      carry_set:   status_q[2],
      carry_clear: status_q[3]
   };

   assign ctrl_except_o = except_q;
   assign pc_ctrl_o     = pc_q;

   // the control unit must never take a new instruction in a flush cycle
   flush_blocks_advance: assert property (@(posedge clk) disable iff (rst)
      !(pipeline_flush_i && padv_execute_i));

endmodule

// ==== source/load_store_unit.sv ====
// load/store unit with a small internal data memory
// checks alignment and range when an access starts, then completes after one
// or three cycles depending on address bit 2; loads are sign or zero extended
`timescale 1ns/1ps

module load_store_unit #(
   parameter int DMEM_WORDS = 64
) (
   input  logic                     clk,
   input  logic                     rst,
   input  cpu_tail_pkg::ctrl_insn_t ctrl_i,
   input  logic                     kill_i,
   output logic                     lsu_valid_o,
   output logic                     lsu_except_dbus_o,
   output logic                     lsu_except_align_o,
   output cpu_tail_pkg::word_t      rdata_o
);

   localparam int AW = $clog2(DMEM_WORDS);

   typedef enum logic [1:0] {IDLE, BUSY, DONE} lsu_state_e;

   lsu_state_e          state_q;
   logic                cnt_q;
   cpu_tail_pkg::word_t mem_q [DMEM_WORDS] = '{default: '0};
   logic [AW-1:0]       idx;
   logic                is_mem;
   logic                misalign;
   logic                out_range;
   logic                start;
   cpu_tail_pkg::word_t rword;
   logic [7:0]          rbyte;
   logic [15:0]         rhalf;

   assign is_mem    = (ctrl_i.op == cpu_tail_pkg::OP_LOAD) |
                      (ctrl_i.op == cpu_tail_pkg::OP_STORE);
   assign misalign  = (ctrl_i.lsu_length == 2'd1) ? ctrl_i.lsu_adr[0] :
                      (ctrl_i.lsu_length != 2'd0) ? |ctrl_i.lsu_adr[1:0] : 1'b0;
   assign out_range = (ctrl_i.lsu_adr >> (AW + 2)) != '0;
   assign start     = (state_q == IDLE) & is_mem & !kill_i;
   assign idx       = ctrl_i.lsu_adr[AW+1:2];

   assign lsu_except_align_o = start & misalign;
   assign lsu_except_dbus_o  = start & out_range;
   assign lsu_valid_o        = state_q == DONE;

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= IDLE;
         cnt_q   <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (start & !misalign & !out_range) begin
                  // bit 2 set selects the slow path
                  state_q <= ctrl_i.lsu_adr[2] ? BUSY : DONE;
                  cnt_q   <= 1'b1;
               end
            end
            BUSY: begin
               if (cnt_q) begin
                  cnt_q <= 1'b0;
               end else begin
                  state_q <= DONE;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // stores land in the completion cycle, byte lanes little endian
   always_ff @(posedge clk) begin
      if ((state_q == DONE) && (ctrl_i.op == cpu_tail_pkg::OP_STORE)) begin
         case (ctrl_i.lsu_length)
            2'd0:    mem_q[idx][8*ctrl_i.lsu_adr[1:0] +: 8] <= ctrl_i.rfb[7:0];
            2'd1:    mem_q[idx][16*ctrl_i.lsu_adr[1] +: 16] <= ctrl_i.rfb[15:0];
            default: mem_q[idx] <= ctrl_i.rfb;
         endcase
      end
   end

   always_comb begin
      rword = mem_q[idx];
      rbyte = rword[8*ctrl_i.lsu_adr[1:0] +: 8];
      rhalf = rword[16*ctrl_i.lsu_adr[1] +: 16];
      case (ctrl_i.lsu_length)
         2'd0:    rdata_o = ctrl_i.lsu_zext ? {24'd0, rbyte} : {{24{rbyte[7]}}, rbyte};
         2'd1:    rdata_o = ctrl_i.lsu_zext ? {16'd0, rhalf} : {{16{rhalf[15]}}, rhalf};
         default: rdata_o = rword;
      endcase
   end

endmodule

// ==== source/pipeline_ctrl.sv ====
// pipeline control for the tail
// derives the wait and advance strobes, prioritizes the latched exception
// causes and raises a one-cycle flush with the exception report
`timescale 1ns/1ps

module pipeline_ctrl (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   exe_valid_i,
   input  cpu_tail_pkg::op_kind_e ctrl_op_i,
   input  logic [5:0]             ctrl_except_i,
   input  cpu_tail_pkg::addr_t    pc_ctrl_i,
   input  logic                   lsu_valid_i,
   input  logic                   mfspr_ack_i,
   input  logic                   mtspr_ack_i,
   output logic                   padv_execute_o,
   output logic                   padv_ctrl_o,
   output logic                   pipeline_flush_o,
   output cpu_tail_pkg::except_t  except_o
);

   logic                        bus_op;
   logic                        waiting;
   logic                        except_sent_q;
   logic                        except_new;
   cpu_tail_pkg::except_cause_e cause;

   assign bus_op = (ctrl_op_i == cpu_tail_pkg::OP_LOAD) |
                   (ctrl_op_i == cpu_tail_pkg::OP_STORE);

   // only bus and SPR accesses hold the control stage
   assign waiting = (bus_op & !lsu_valid_i) |
                    ((ctrl_op_i == cpu_tail_pkg::OP_MFSPR) & !mfspr_ack_i) |
                    ((ctrl_op_i == cpu_tail_pkg::OP_MTSPR) & !mtspr_ack_i);

   assign except_new       = (|ctrl_except_i) & !except_sent_q;
   assign pipeline_flush_o = except_new;
   assign padv_execute_o   = exe_valid_i & !waiting & !pipeline_flush_o;
   assign padv_ctrl_o      = (ctrl_op_i != cpu_tail_pkg::OP_NOP) & !waiting & !pipeline_flush_o;

   // scan from the lowest priority up so that the first set bit wins
   always_comb begin
      cause = cpu_tail_pkg::EXC_NONE;
      for (int i = 5; i >= 0; i--) begin
         if (ctrl_except_i[i]) begin
            cause = cpu_tail_pkg::except_cause_e'(i + 1);
         end
      end
   end

   assign except_o = '{valid: except_new, cause: cause, epc: pc_ctrl_i};

   always_ff @(posedge clk) begin
      if (rst) begin
         except_sent_q <= 1'b0;
      end else begin
         except_sent_q <= except_new;
      end
   end

   // the flush empties the control stage, so the faulting instruction never retires
   flush_empties_ctrl: assert property (@(posedge clk) disable iff (rst)
      pipeline_flush_o |=> (ctrl_op_i == cpu_tail_pkg::OP_NOP) && (ctrl_except_i == '0));

endmodule

// ==== source/spr_file.sv ====
// special-purpose register file, eight words
// an SPR op in the control stage is acknowledged SPR_ACK_DELAY cycles after it
// arrives; mtspr writes on its ack, mfspr data is valid during its ack
`timescale 1ns/1ps

module spr_file #(
   parameter int SPR_ACK_DELAY = 2
) (
   input  logic                   clk,
   input  logic                   rst,
   input  cpu_tail_pkg::op_kind_e ctrl_op_i,
   input  cpu_tail_pkg::spr_adr_t spr_adr_i,
   input  cpu_tail_pkg::word_t    wdata_i,
   output logic                   mfspr_ack_o,
   output logic                   mtspr_ack_o,
   output cpu_tail_pkg::word_t    rdata_o
);

   localparam int CW = (SPR_ACK_DELAY > 0) ? $clog2(SPR_ACK_DELAY + 1) : 1;

   cpu_tail_pkg::word_t spr_q [8];
   logic [CW-1:0]       cnt_q;
   logic                is_spr;
   logic                fire;

   assign is_spr = (ctrl_op_i == cpu_tail_pkg::OP_MFSPR) |
                   (ctrl_op_i == cpu_tail_pkg::OP_MTSPR);
   assign fire   = is_spr & (cnt_q == CW'(SPR_ACK_DELAY));

   assign mfspr_ack_o = fire & (ctrl_op_i == cpu_tail_pkg::OP_MFSPR);
   assign mtspr_ack_o = fire & (ctrl_op_i == cpu_tail_pkg::OP_MTSPR);
   assign rdata_o     = spr_q[spr_adr_i];

   // restarts from zero after each ack and whenever the stage holds no SPR op
   always_ff @(posedge clk) begin
      if (rst) begin
         cnt_q <= '0;
      end else if (is_spr & !fire) begin
         cnt_q <= cnt_q + 1'b1;
      end else begin
         cnt_q <= '0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         spr_q <= '{default: '0};
      end else if (mtspr_ack_o) begin
         spr_q[spr_adr_i] <= wdata_i;
      end
   end

endmodule

// ==== source/writeback_stage.sv ====
// writeback register and status bits
// latches the data of the instruction leaving the control stage and applies
// its flag and carry pulses; set takes priority over clear
`timescale 1ns/1ps

module writeback_stage (
   input  logic                     clk,
   input  logic                     rst,
   input  cpu_tail_pkg::ctrl_insn_t ctrl_i,
   input  logic                     wb_rf_wb_i,
   input  cpu_tail_pkg::reg_adr_t   wb_rfd_adr_i,
   input  cpu_tail_pkg::word_t      lsu_rdata_i,
   input  cpu_tail_pkg::word_t      spr_rdata_i,
   input  logic                     padv_ctrl_i,
   output cpu_tail_pkg::wb_t        wb_o,
   output logic                     flag_o,
   output logic                     carry_o
);

   cpu_tail_pkg::word_t wb_data;
   cpu_tail_pkg::word_t wb_data_q;

   always_comb begin
      case (ctrl_i.op)
         cpu_tail_pkg::OP_LOAD:  wb_data = lsu_rdata_i;
         cpu_tail_pkg::OP_MFSPR: wb_data = spr_rdata_i;
         default:                wb_data = ctrl_i.result;
      endcase
   end

   // padv_ctrl marks the completing cycle of every op, so the data lines up
   // with the write enable registered on the same edge
   always_ff @(posedge clk) begin
      if (padv_ctrl_i) begin
         wb_data_q <= wb_data;
      end
   end

   assign wb_o = '{we: wb_rf_wb_i, adr: wb_rfd_adr_i, data: wb_data_q};

   always_ff @(posedge clk) begin
      if (rst) begin
         flag_o  <= 1'b0;
         carry_o <= 1'b0;
      end else if (padv_ctrl_i) begin
         if (ctrl_i.flag_set) begin
            flag_o <= 1'b1;
         end else if (ctrl_i.flag_clear) begin
            flag_o <= 1'b0;
         end
         if (ctrl_i.carry_set) begin
            carry_o <= 1'b1;
         end else if (ctrl_i.carry_clear) begin
            carry_o <= 1'b0;
         end
      end
   end

endmodule
